//--- hdl/axil_pack_pkg.sv
// ==============================
// AXI response and protection enums
// Field widths of the packed command word
// ==============================

package axil_pack_pkg;

  // AXI response codes
  typedef enum logic [1:0]
  {
    e_axi_resp_okay   = 2'b00,
    e_axi_resp_exokay = 2'b01,
    e_axi_resp_slverr = 2'b10,
    e_axi_resp_decerr = 2'b11
  } axi_resp_type_e;

  // Bit 0 privileged, bit 1 non-secure, bit 2 instruction
  typedef enum logic [2:0]
  {
    e_axi_prot_default   = 3'b000,
    e_axi_prot_priv      = 3'b001,
    e_axi_prot_nonsecure = 3'b010,
    e_axi_prot_instr     = 3'b100
  } axi_prot_type_e;

  // Command word is {write_not_read, addr, data}
  localparam int cmd_width_c      = 32;
  localparam int payload_width_c  = 8;
  localparam int cmd_addr_width_c = cmd_width_c - payload_width_c - 1;

endpackage

//--- hdl/axil_store_packer.sv
// ==============================
// AXI-Lite slave port to packed command stream
// One transaction outstanding, reads block on reply
// ==============================

module axil_store_packer
  import axil_pack_pkg::*;
#(
  parameter int axil_addr_width_p = 32
)
(
  input                                clk_i,
  input                                reset_i,

  // Write address
  input        [axil_addr_width_p-1:0] s_axil_awaddr_i,
  input        axi_prot_type_e         s_axil_awprot_i,
  input                                s_axil_awvalid_i,
  output logic                         s_axil_awready_o,

  // Write data
  input        [cmd_width_c-1:0]       s_axil_wdata_i,
  input        [(cmd_width_c/8)-1:0]   s_axil_wstrb_i,
  input                                s_axil_wvalid_i,
  output logic                         s_axil_wready_o,

  // Write response
  output       axi_resp_type_e         s_axil_bresp_o,
  output logic                         s_axil_bvalid_o,
  input                                s_axil_bready_i,

  // Read address
  input        [axil_addr_width_p-1:0] s_axil_araddr_i,
  input        axi_prot_type_e         s_axil_arprot_i,
  input                                s_axil_arvalid_i,
  output logic                         s_axil_arready_o,

  // Read data
  output logic [cmd_width_c-1:0]       s_axil_rdata_o,
  output       axi_resp_type_e         s_axil_rresp_o,
  output logic                         s_axil_rvalid_o,
  input                                s_axil_rready_i,

  // Command out
  output logic [cmd_width_c-1:0]       data_o,
  output logic                         v_o,
  input                                ready_i,

  // Read reply in
  input        [cmd_width_c-1:0]       data_i,
  input                                v_i,
  output logic                         ready_o
);

  typedef enum logic [1:0]
  {
    e_idle,
    e_read_req,
    e_read_resp,
    e_write_resp
  } state_e;

  state_e state_r;
  state_e state_n;

  wire is_idle       = (state_r == e_idle);
  wire is_read_req   = (state_r == e_read_req);
  wire is_read_resp  = (state_r == e_read_resp);
  wire is_write_resp = (state_r == e_write_resp);

  // Address fields sized to the command word
  wire [cmd_addr_width_c-1:0] aw_field = cmd_addr_width_c'(s_axil_awaddr_i);
  wire [cmd_addr_width_c-1:0] ar_field = cmd_addr_width_c'(s_axil_araddr_i);

  // Only the low byte of write data is carried
  wire [cmd_width_c-1:0] write_cmd = {1'b1, aw_field, s_axil_wdata_i[payload_width_c-1:0]};
  wire [cmd_width_c-1:0] read_cmd  = {1'b0, ar_field, {payload_width_c{1'b0}}};

  wire write_fire = is_idle & s_axil_awvalid_i & s_axil_wvalid_i & ready_i;
  wire read_fire  = is_read_req & s_axil_arvalid_i & ready_i;

  // Address and data are taken together, never one channel alone
  assign s_axil_awready_o = write_fire;
  assign s_axil_wready_o  = write_fire;
  assign s_axil_arready_o = is_read_req & ready_i;

  // Errors never reported
  assign s_axil_bresp_o = e_axi_resp_okay;
  assign s_axil_rresp_o = e_axi_resp_okay;

  assign s_axil_bvalid_o = is_write_resp;
  assign s_axil_rvalid_o = is_read_resp & v_i;
  assign s_axil_rdata_o  = data_i;
  assign ready_o         = is_read_resp & s_axil_rready_i;

  // Command goes out in the same cycle the channel is accepted
  assign v_o    = write_fire | read_fire;
  assign data_o = is_read_req ? read_cmd : write_cmd;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
      begin
        // Writes win over a pending read address
        if (write_fire)
          state_n = e_write_resp;
        else if (s_axil_arvalid_i)
          state_n = e_read_req;
      end
      e_read_req:
      begin
        if (read_fire)
          state_n = e_read_resp;
      end
      e_read_resp:
      begin
        if (s_axil_rvalid_o & s_axil_rready_i)
          state_n = e_idle;
      end
      e_write_resp:
      begin
        if (s_axil_bready_i)
          state_n = e_idle;
      end
      default:
      begin
        state_n = e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

endmodule

//--- hdl/cmd_arbiter.sv
// ==============================
// Two-port command merge with
// alternating grant slot and read reply routing
// ==============================

module cmd_arbiter
  import axil_pack_pkg::*;
(
  input                          clk_i,
  input                          reset_i,

  input        [cmd_width_c-1:0] a_cmd_data_i,
  input                          a_cmd_v_i,
  output logic                   a_cmd_ready_o,

  input        [cmd_width_c-1:0] b_cmd_data_i,
  input                          b_cmd_v_i,
  output logic                   b_cmd_ready_o,

  output logic [cmd_width_c-1:0] a_rsp_data_o,
  output logic                   a_rsp_v_o,
  input                          a_rsp_ready_i,

  output logic [cmd_width_c-1:0] b_rsp_data_o,
  output logic                   b_rsp_v_o,
  input                          b_rsp_ready_i,

  output logic [cmd_width_c-1:0] mem_cmd_data_o,
  output logic                   mem_cmd_v_o,

  input        [cmd_width_c-1:0] mem_rsp_data_i,
  input                          mem_rsp_v_i,
  output logic                   mem_rsp_ready_o
);

  // Priority bit, low selects port a
  logic prio_r;
  logic pending_r;
  logic owner_r;

  // Grant slot is not tied to cmd_v, which keeps the packer handshake loop-free
  wire slot_open = ~pending_r;

  assign a_cmd_ready_o = slot_open & ~prio_r;
  assign b_cmd_ready_o = slot_open & prio_r;

  assign mem_cmd_v_o    = (a_cmd_v_i & a_cmd_ready_o) | (b_cmd_v_i & b_cmd_ready_o);
  assign mem_cmd_data_o = prio_r ? b_cmd_data_i : a_cmd_data_i;

  wire read_issue = mem_cmd_v_o & ~mem_cmd_data_o[cmd_width_c-1];
  wire rsp_done   = mem_rsp_v_i & mem_rsp_ready_o;

  // Reply goes only to the port that issued the read
  assign a_rsp_data_o    = mem_rsp_data_i;
  assign b_rsp_data_o    = mem_rsp_data_i;
  assign a_rsp_v_o       = mem_rsp_v_i & pending_r & ~owner_r;
  assign b_rsp_v_o       = mem_rsp_v_i & pending_r & owner_r;
  assign mem_rsp_ready_o = pending_r & (owner_r ? b_rsp_ready_i : a_rsp_ready_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      prio_r    <= 1'b0;
      pending_r <= 1'b0;
      owner_r   <= 1'b0;
    end
    else
    begin
      // Slot passes to the other port after every offered grant
      if (slot_open)
        prio_r <= ~prio_r;

      if (read_issue)
      begin
        pending_r <= 1'b1;
        owner_r   <= prio_r;
      end
      else if (rsp_done)
        pending_r <= 1'b0;
    end
  end

endmodule

//--- hdl/byte_store.sv
// ==============================
// Byte memory driven by packed commands
// ==============================

module byte_store
  import axil_pack_pkg::*;
#(
  parameter int store_addr_width_p = 8
)
(
  input                          clk_i,
  input                          reset_i,

  input        [cmd_width_c-1:0] cmd_data_i,
  input                          cmd_v_i,

  output logic [cmd_width_c-1:0] rsp_data_o,
  output logic                   rsp_v_o,
  input                          rsp_ready_i
);

  localparam int depth_lp = 1 << store_addr_width_p;

  logic [payload_width_c-1:0] mem_r [depth_lp];

  // Command fields, address truncated to the store depth
  wire                          cmd_write = cmd_data_i[cmd_width_c-1];
  wire [store_addr_width_p-1:0] cmd_addr  = cmd_data_i[payload_width_c +: store_addr_width_p];
  wire [payload_width_c-1:0]    cmd_byte  = cmd_data_i[payload_width_c-1:0];

  wire do_write = cmd_v_i & cmd_write;
  wire do_read  = cmd_v_i & ~cmd_write;

  always_ff @(posedge clk_i)
  begin
    if (do_write)
      mem_r[cmd_addr] <= cmd_byte;
  end

  // Reply data held until taken
  always_ff @(posedge clk_i)
  begin
    if (do_read)
      rsp_data_o <= cmd_width_c'(mem_r[cmd_addr]);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rsp_v_o <= 1'b0;
    else if (do_read)
      rsp_v_o <= 1'b1;
    else if (rsp_ready_i)
      rsp_v_o <= 1'b0;
  end

endmodule

//--- hdl/dual_axil_store_top.sv
// ==============================
// Two AXI-Lite ports sharing one byte store
// Packers, arbiter and store
// ==============================

module dual_axil_store_top
  import axil_pack_pkg::*;
#(
  parameter int axil_addr_width_p  = 32,
  parameter int store_addr_width_p = 8
)
(
  input                                clk_i,
  input                                reset_i,

  // Port a
  input        [axil_addr_width_p-1:0] a_s_axil_awaddr_i,
  input        axi_prot_type_e         a_s_axil_awprot_i,
  input                                a_s_axil_awvalid_i,
  output logic                         a_s_axil_awready_o,
  input        [cmd_width_c-1:0]       a_s_axil_wdata_i,
  input        [(cmd_width_c/8)-1:0]   a_s_axil_wstrb_i,
  input                                a_s_axil_wvalid_i,
  output logic                         a_s_axil_wready_o,
  output       axi_resp_type_e         a_s_axil_bresp_o,
  output logic                         a_s_axil_bvalid_o,
  input                                a_s_axil_bready_i,
  input        [axil_addr_width_p-1:0] a_s_axil_araddr_i,
  input        axi_prot_type_e         a_s_axil_arprot_i,
  input                                a_s_axil_arvalid_i,
  output logic                         a_s_axil_arready_o,
  output logic [cmd_width_c-1:0]       a_s_axil_rdata_o,
  output       axi_resp_type_e         a_s_axil_rresp_o,
  output logic                         a_s_axil_rvalid_o,
  input                                a_s_axil_rready_i,

  // Port b
  input        [axil_addr_width_p-1:0] b_s_axil_awaddr_i,
  input        axi_prot_type_e         b_s_axil_awprot_i,
  input                                b_s_axil_awvalid_i,
  output logic                         b_s_axil_awready_o,
  input        [cmd_width_c-1:0]       b_s_axil_wdata_i,
  input        [(cmd_width_c/8)-1:0]   b_s_axil_wstrb_i,
  input                                b_s_axil_wvalid_i,
  output logic                         b_s_axil_wready_o,
  output       axi_resp_type_e         b_s_axil_bresp_o,
  output logic                         b_s_axil_bvalid_o,
  input                                b_s_axil_bready_i,
  input        [axil_addr_width_p-1:0] b_s_axil_araddr_i,
  input        axi_prot_type_e         b_s_axil_arprot_i,
  input                                b_s_axil_arvalid_i,
  output logic                         b_s_axil_arready_o,
  output logic [cmd_width_c-1:0]       b_s_axil_rdata_o,
  output       axi_resp_type_e         b_s_axil_rresp_o,
  output logic                         b_s_axil_rvalid_o,
  input                                b_s_axil_rready_i
);

  // Packer to arbiter
  logic [cmd_width_c-1:0] a_cmd_data, b_cmd_data;
  logic                   a_cmd_v, b_cmd_v;
  logic                   a_cmd_ready, b_cmd_ready;
  logic [cmd_width_c-1:0] a_rsp_data, b_rsp_data;
  logic                   a_rsp_v, b_rsp_v;
  logic                   a_rsp_ready, b_rsp_ready;

  // Arbiter to store
  logic [cmd_width_c-1:0] mem_cmd_data;
  logic                   mem_cmd_v;
  logic [cmd_width_c-1:0] mem_rsp_data;
  logic                   mem_rsp_v;
  logic                   mem_rsp_ready;

  axil_store_packer #(.axil_addr_width_p(axil_addr_width_p)) packer_a
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .s_axil_awaddr_i(a_s_axil_awaddr_i), .s_axil_awprot_i(a_s_axil_awprot_i),
    .s_axil_awvalid_i(a_s_axil_awvalid_i), .s_axil_awready_o(a_s_axil_awready_o),
    .s_axil_wdata_i(a_s_axil_wdata_i), .s_axil_wstrb_i(a_s_axil_wstrb_i),
    .s_axil_wvalid_i(a_s_axil_wvalid_i), .s_axil_wready_o(a_s_axil_wready_o),
    .s_axil_bresp_o(a_s_axil_bresp_o), .s_axil_bvalid_o(a_s_axil_bvalid_o),
    .s_axil_bready_i(a_s_axil_bready_i),
    .s_axil_araddr_i(a_s_axil_araddr_i), .s_axil_arprot_i(a_s_axil_arprot_i),
    .s_axil_arvalid_i(a_s_axil_arvalid_i), .s_axil_arready_o(a_s_axil_arready_o),
    .s_axil_rdata_o(a_s_axil_rdata_o), .s_axil_rresp_o(a_s_axil_rresp_o),
    .s_axil_rvalid_o(a_s_axil_rvalid_o), .s_axil_rready_i(a_s_axil_rready_i),
    .data_o(a_cmd_data), .v_o(a_cmd_v), .ready_i(a_cmd_ready),
    .data_i(a_rsp_data), .v_i(a_rsp_v), .ready_o(a_rsp_ready)
  );

  axil_store_packer #(.axil_addr_width_p(axil_addr_width_p)) packer_b
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .s_axil_awaddr_i(b_s_axil_awaddr_i), .s_axil_awprot_i(b_s_axil_awprot_i),
    .s_axil_awvalid_i(b_s_axil_awvalid_i), .s_axil_awready_o(b_s_axil_awready_o),
    .s_axil_wdata_i(b_s_axil_wdata_i), .s_axil_wstrb_i(b_s_axil_wstrb_i),
    .s_axil_wvalid_i(b_s_axil_wvalid_i), .s_axil_wready_o(b_s_axil_wready_o),
    .s_axil_bresp_o(b_s_axil_bresp_o), .s_axil_bvalid_o(b_s_axil_bvalid_o),
    .s_axil_bready_i(b_s_axil_bready_i),
    .s_axil_araddr_i(b_s_axil_araddr_i), .s_axil_arprot_i(b_s_axil_arprot_i),
    .s_axil_arvalid_i(b_s_axil_arvalid_i), .s_axil_arready_o(b_s_axil_arready_o),
    .s_axil_rdata_o(b_s_axil_rdata_o), .s_axil_rresp_o(b_s_axil_rresp_o),
    .s_axil_rvalid_o(b_s_axil_rvalid_o), .s_axil_rready_i(b_s_axil_rready_i),
    .data_o(b_cmd_data), .v_o(b_cmd_v), .ready_i(b_cmd_ready),
    .data_i(b_rsp_data), .v_i(b_rsp_v), .ready_o(b_rsp_ready)
  );

  cmd_arbiter u_arbiter
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .a_cmd_data_i(a_cmd_data), .a_cmd_v_i(a_cmd_v), .a_cmd_ready_o(a_cmd_ready),
    .b_cmd_data_i(b_cmd_data), .b_cmd_v_i(b_cmd_v), .b_cmd_ready_o(b_cmd_ready),
    .a_rsp_data_o(a_rsp_data), .a_rsp_v_o(a_rsp_v), .a_rsp_ready_i(a_rsp_ready),
    .b_rsp_data_o(b_rsp_data), .b_rsp_v_o(b_rsp_v), .b_rsp_ready_i(b_rsp_ready),
    .mem_cmd_data_o(mem_cmd_data), .mem_cmd_v_o(mem_cmd_v),
    .mem_rsp_data_i(mem_rsp_data), .mem_rsp_v_i(mem_rsp_v),
    .mem_rsp_ready_o(mem_rsp_ready)
  );

  byte_store #(.store_addr_width_p(store_addr_width_p)) u_store
  (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_data_i(mem_cmd_data), .cmd_v_i(mem_cmd_v),
    .rsp_data_o(mem_rsp_data), .rsp_v_o(mem_rsp_v), .rsp_ready_i(mem_rsp_ready)
  );

endmodule

//--- test/dual_axil_store_checker.sv
// ==============================
// Bound assertions for one AXI-Lite port
// Reset state, response hold until ready
// and OKAY response codes
// ==============================

module dual_axil_store_checker
  import axil_pack_pkg::*;
(
  input                   clk_i,
  input                   reset_i,
  input                   bvalid_i,
  input                   bready_i,
  input axi_resp_type_e   bresp_i,
  input                   rvalid_i,
  input                   rready_i,
  input [cmd_width_c-1:0] rdata_i,
  input axi_resp_type_e   rresp_i
);

  // Read by the testbench for its verdict
  int fail_count = 0;

  reset_quiet: assert property (@(posedge clk_i) reset_i |=> !bvalid_i && !rvalid_i)
  else
  begin
    $error("response valid during or right after reset");
    fail_count++;
  end

  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
  else
  begin
    $error("bvalid dropped before bready");
    fail_count++;
  end

  // Data must not move while the reply waits
  r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
  else
  begin
    $error("rvalid dropped or rdata changed before rready");
    fail_count++;
  end

  b_okay: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i |-> bresp_i == e_axi_resp_okay)
  else
  begin
    $error("bresp is not OKAY while bvalid");
    fail_count++;
  end

  r_okay: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i |-> rresp_i == e_axi_resp_okay)
  else
  begin
    $error("rresp is not OKAY while rvalid");
    fail_count++;
  end

endmodule

bind dual_axil_store_top dual_axil_store_checker a_checker
(
  .clk_i(clk_i), .reset_i(reset_i),
  .bvalid_i(a_s_axil_bvalid_o), .bready_i(a_s_axil_bready_i), .bresp_i(a_s_axil_bresp_o),
  .rvalid_i(a_s_axil_rvalid_o), .rready_i(a_s_axil_rready_i), .rdata_i(a_s_axil_rdata_o),
  .rresp_i(a_s_axil_rresp_o)
);

bind dual_axil_store_top dual_axil_store_checker b_checker
(
  .clk_i(clk_i), .reset_i(reset_i),
  .bvalid_i(b_s_axil_bvalid_o), .bready_i(b_s_axil_bready_i), .bresp_i(b_s_axil_bresp_o),
  .rvalid_i(b_s_axil_rvalid_o), .rready_i(b_s_axil_rready_i), .rdata_i(b_s_axil_rdata_o),
  .rresp_i(b_s_axil_rresp_o)
);

//--- test/dual_axil_store_tb.sv
// ==============================
// Testbench for the dual-port byte store
// Clock, reset, AXI-Lite write and read tasks,
// byte model, per-test report, watchdog
// ==============================

module dual_axil_store_tb
  import axil_pack_pkg::*;
;

  localparam bit port_a = 1'b0;
  localparam bit port_b = 1'b1;

  localparam int n_single_lp = 12;
  localparam int n_cross_lp  = 6;
  localparam int n_alias_lp  = 6;
  // Reads and writes issued over all tests
  localparam int txn_count_lp = 2 * n_single_lp + 2 * n_cross_lp + 10 + 2 * n_alias_lp + 8;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] awaddr [2];
  logic [31:0] wdata [2];
  logic [31:0] araddr [2];
  logic [1:0]  awvalid;
  logic [1:0]  wvalid;
  logic [1:0]  bready;
  logic [1:0]  arvalid;
  logic [1:0]  rready;
  wire  [1:0]  awready;
  wire  [1:0]  wready;
  wire  [1:0]  bvalid;
  wire  [1:0]  arready;
  wire  [1:0]  rvalid;
  wire  [31:0] rdata [2];

  // Expected store contents, low 8 address bits
  logic [7:0] ref_mem [256];

  int errors = 0;
  int tests_run = 0;
  int errors_before = 0;

  dual_axil_store_top #(.axil_addr_width_p(32), .store_addr_width_p(8)) uut
  (
    .clk_i(clk), .reset_i(reset),
    .a_s_axil_awaddr_i(awaddr[0]), .a_s_axil_awprot_i(e_axi_prot_default),
    .a_s_axil_awvalid_i(awvalid[0]), .a_s_axil_awready_o(awready[0]),
    .a_s_axil_wdata_i(wdata[0]), .a_s_axil_wstrb_i(4'hf),
    .a_s_axil_wvalid_i(wvalid[0]), .a_s_axil_wready_o(wready[0]),
    .a_s_axil_bresp_o(), .a_s_axil_bvalid_o(bvalid[0]), .a_s_axil_bready_i(bready[0]),
    .a_s_axil_araddr_i(araddr[0]), .a_s_axil_arprot_i(e_axi_prot_default),
    .a_s_axil_arvalid_i(arvalid[0]), .a_s_axil_arready_o(arready[0]),
    .a_s_axil_rdata_o(rdata[0]), .a_s_axil_rresp_o(),
    .a_s_axil_rvalid_o(rvalid[0]), .a_s_axil_rready_i(rready[0]),
    .b_s_axil_awaddr_i(awaddr[1]), .b_s_axil_awprot_i(e_axi_prot_default),
    .b_s_axil_awvalid_i(awvalid[1]), .b_s_axil_awready_o(awready[1]),
    .b_s_axil_wdata_i(wdata[1]), .b_s_axil_wstrb_i(4'hf),
    .b_s_axil_wvalid_i(wvalid[1]), .b_s_axil_wready_o(wready[1]),
    .b_s_axil_bresp_o(), .b_s_axil_bvalid_o(bvalid[1]), .b_s_axil_bready_i(bready[1]),
    .b_s_axil_araddr_i(araddr[1]), .b_s_axil_arprot_i(e_axi_prot_default),
    .b_s_axil_arvalid_i(arvalid[1]), .b_s_axil_arready_o(arready[1]),
    .b_s_axil_rdata_o(rdata[1]), .b_s_axil_rresp_o(),
    .b_s_axil_rvalid_o(rvalid[1]), .b_s_axil_rready_i(rready[1])
  );

  always #2 clk = ~clk;

  // Middle of the low phase, where DUT outputs are settled
  task automatic step_cycle();
    @(negedge clk);
    #1;
  endtask

  function automatic int error_total();
    return errors + uut.a_checker.fail_count + uut.b_checker.fail_count;
  endfunction

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, error_total() - errors_before);
    errors_before = error_total();
  endtask

  task automatic check_value(input bit p, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      $display("mismatch %s got %h expected %h", p ? "b_s_axil_rdata_o" : "a_s_axil_rdata_o",
               got, exp);
      errors++;
    end
  endtask

  // bready stays low for hold cycles once bvalid is up
  task automatic axil_write(input bit p, input logic [31:0] addr, input logic [31:0] data,
                            input int hold);
    @(negedge clk);
    awaddr[p] = addr;
    wdata[p] = data;
    awvalid[p] = 1'b1;
    wvalid[p] = 1'b1;
    bready[p] = (hold == 0);
    #1;
    while (!(awready[p] && wready[p])) step_cycle();
    @(negedge clk);
    awvalid[p] = 1'b0;
    wvalid[p] = 1'b0;
    #1;
    while (!bvalid[p]) step_cycle();
    repeat (hold) @(negedge clk);
    bready[p] = 1'b1;
    // Store keeps the low data byte at the low 8 address bits
    ref_mem[addr[7:0]] = data[7:0];
    @(negedge clk);
  endtask

  task automatic axil_read(input bit p, input logic [31:0] addr, input int hold,
                           output logic [31:0] got);
    @(negedge clk);
    araddr[p] = addr;
    arvalid[p] = 1'b1;
    rready[p] = (hold == 0);
    #1;
    while (!arready[p]) step_cycle();
    @(negedge clk);
    arvalid[p] = 1'b0;
    #1;
    while (!rvalid[p]) step_cycle();
    repeat (hold) @(negedge clk);
    got = rdata[p];
    rready[p] = 1'b1;
    @(negedge clk);
  endtask

  task automatic read_expect(input bit p, input logic [31:0] addr, input int hold);
    logic [31:0] got;
    axil_read(p, addr, hold, got);
    check_value(p, got, {24'h0, ref_mem[addr[7:0]]});
  endtask

  initial
  begin
    repeat (10 + txn_count_lp * 50) @(posedge clk);
    $display("watchdog expired after %0d transactions worth of cycles", txn_count_lp);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] data_b;
    logic [31:0] got_a;
    logic [31:0] got_b;
    int          hold;
    int          total;
    void'($urandom(32'hc2da_a75b));
    reset = 1'b1;
    awvalid = '0;
    wvalid = '0;
    arvalid = '0;
    bready = '1;
    rready = '1;
    for (int i = 0; i < 2; i++)
    begin
      awaddr[i] = '0;
      wdata[i] = '0;
      araddr[i] = '0;
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < n_single_lp; i++)
    begin
      addr = $urandom % 256;
      axil_write(port_a, addr, $urandom % 256, 0);
      read_expect(port_a, addr, 0);
    end
    finish_test("port a write and read back");

    // Both ports see one store
    for (int i = 0; i < n_cross_lp; i++)
    begin
      addr = $urandom % 256;
      axil_write(port_a, addr, $urandom % 256, 0);
      read_expect(port_b, addr, 0);
    end
    finish_test("write on a, read on b");

    addr = $urandom % 128;
    data = $urandom % 256;
    data_b = $urandom % 256;
    fork
      axil_write(port_a, addr, data, 0);
      axil_write(port_b, addr + 128, data_b, 0);
    join
    read_expect(port_a, addr + 128, 0);
    read_expect(port_b, addr, 0);
    read_expect(port_a, addr, 0);
    read_expect(port_b, addr + 128, 0);
    // Same address, either write may land last
    fork
      axil_write(port_a, addr, data, 0);
      axil_write(port_b, addr, data_b, 0);
    join
    axil_read(port_a, addr, 0, got_a);
    axil_read(port_b, addr, 0, got_b);
    check_value(port_b, got_b, got_a);
    assert (got_a == data || got_a == data_b)
    else
    begin
      $display("mismatch a_s_axil_rdata_o %h is neither written byte %h nor %h",
               got_a, data, data_b);
      errors++;
    end
    finish_test("simultaneous writes");

    // Upper data bits dropped, upper address bits alias
    for (int i = 0; i < n_alias_lp; i++)
    begin
      addr = $urandom | 32'h0000_0100;
      axil_write(port_a, addr, $urandom | 32'h0000_ff00, 0);
      read_expect(port_b, (addr & 32'hff) | ($urandom << 8), 0);
    end
    finish_test("byte and address truncation");

    addr = $urandom % 128;
    hold = 1 + $urandom % 8;
    fork
      axil_write(port_a, addr, $urandom % 256, hold);
      begin
        for (int i = 0; i < 3; i++)
          axil_write(port_b, 128 + (addr + i) % 128, $urandom % 256, 0);
      end
    join
    read_expect(port_a, addr, 1 + $urandom % 8);
    for (int i = 0; i < 3; i++)
      read_expect(port_b, 128 + (addr + i) % 128, 1 + $urandom % 8);
    finish_test("response back-pressure");

    total = error_total();
    $display("tests %0d, errors %0d", tests_run, total);
    if (total == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- sim.f
hdl/axil_pack_pkg.sv
hdl/axil_store_packer.sv
hdl/cmd_arbiter.sv
hdl/byte_store.sv
hdl/dual_axil_store_top.sv
test/dual_axil_store_checker.sv
test/dual_axil_store_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dual_axil_store_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
SIM_FLAGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
